// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= spi_bridge_tb
RTL_TOP    ?= spi_bridge_top
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TB PASSED" \
		&& echo "simulation passed" \
		|| (echo "simulation failed"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
common/spi_bridge_pkg.sv
common/spi_cmd_if.sv
common/spi_result_if.sv
hw/ipif_reg_decode.sv
spi_engine/spi_byte_master.sv
hw/spi_result_capture.sv
hw/spi_bridge_top.sv
bench/spi_chip_model.sv
bench/spi_bridge_tb.sv

// ==== bench/spi_bridge_tb.sv ====
// testbench for the spi bridge, drives the register port and checks frames against a chip model
`default_nettype none

module spi_bridge_tb;

   localparam int CLK_DIV = 4;
   localparam int LIMIT = 30 * (spi_bridge_pkg::FRAME_BITS * 2 * CLK_DIV + 20);
   localparam logic [31:0] GO = 32'h1 << spi_bridge_pkg::CTRL_GO_BIT;
   localparam logic [31:0] SRN = 32'h1 << spi_bridge_pkg::CTRL_SOFT_RSTN_BIT;

   logic        clk;
   logic        arst_n;
   logic [3:0]  bus_wrce;
   logic [3:0]  bus_rdce;
   logic [31:0] bus_wdata;
   logic [31:0] bus_rdata;
   logic        bus_wrack;
   logic        bus_rdack;
   logic        bus_error;
   logic        serial_in;
   logic        spi_clk;
   logic        serial_out;

   logic [31:0] lfsr;
   logic [7:0]  ref_mem [128];
   logic [31:0] exp_mask;
   logic [31:0] exp_val;
   logic [15:0] exp_frame;
   logic        spi_clk_q;
   logic        rise_clr;
   logic        rise_chk;
   logic        mem_chk;
   logic        sr_chk;
   logic [6:0]  chk_addr;
   logic [7:0]  chk_data;
   int          rise_cnt;
   int          cycles;
   wire         rise_now = spi_clk && !spi_clk_q;

   spi_bridge_top #(.CLK_DIV(CLK_DIV)) dut (
      .clk(clk), .arst_n(arst_n), .bus_wrce(bus_wrce), .bus_rdce(bus_rdce),
      .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_wrack(bus_wrack),
      .bus_rdack(bus_rdack), .bus_error(bus_error), .serial_in(serial_in),
      .spi_clk(spi_clk), .serial_out(serial_out)
   );

   spi_chip_model chip (.clk(clk), .spi_clk(spi_clk), .mosi(serial_out), .miso(serial_in));

   task automatic stop_failed(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "run stopped on error");
   endtask

   // galois lfsr, one step per bit taken
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic bus_write(input int idx, input logic [31:0] data);
      @(negedge clk);
      bus_wrce  = 4'(1 << idx);
      bus_wdata = data;
      @(negedge clk);
      bus_wrce = '0;
   endtask

   task automatic bus_read(input int idx, input logic [31:0] mask, input logic [31:0] val,
                           output logic [31:0] rd);
      @(negedge clk);
      bus_rdce = 4'(1 << idx);
      exp_mask = mask;
      exp_val  = val;
      @(negedge clk);
      bus_rdce = '0;
      rd = bus_rdata; // rdack cycle
   endtask

   task automatic pulse(ref logic sig);
      @(negedge clk);
      sig = 1'b1;
      @(negedge clk);
      sig = 1'b0;
   endtask

   task automatic wait_done();
      logic [31:0] rd;
      int          polls;
      rd = '0;
      polls = 0;
      while (!rd[spi_bridge_pkg::STAT_DONE_BIT]) begin
         if (polls > 200)
            stop_failed("done bit never set after a command");
         bus_read(spi_bridge_pkg::REG_STATUS, 32'h0, 32'h0, rd);
         polls++;
      end
   endtask

   task automatic start_frame(input logic [7:0] addr, input logic [7:0] data);
      bus_write(spi_bridge_pkg::REG_WDATA, 32'(data));
      bus_write(spi_bridge_pkg::REG_ADDR, 32'(addr));
      exp_frame = {addr, data};
      pulse(rise_clr);
      bus_write(spi_bridge_pkg::REG_CTRL, GO | SRN);
   endtask

   task automatic run_frame(input logic [7:0] addr, input logic [7:0] data);
      logic [31:0] rd;
      start_frame(addr, data);
      wait_done();
      pulse(rise_chk);
      if (addr[7]) begin
         bus_read(spi_bridge_pkg::REG_STATUS, 32'h3FF, 32'(ref_mem[addr[6:0]]), rd);
      end else begin
         ref_mem[addr[6:0]] = data;
         chk_addr = addr[6:0];
         chk_data = data;
         pulse(mem_chk);
         bus_read(spi_bridge_pkg::REG_STATUS, 32'h300, 32'h0, rd); // busy and done low
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      spi_clk_q <= spi_clk;
      if (rise_clr)
         rise_cnt <= 0;
      else if (rise_now)
         rise_cnt <= rise_cnt + 1;
      cycles <= cycles + 1;
      if (cycles >= LIMIT)
         stop_failed("timeout, the tests did not finish within the cycle limit");
   end

   a_wrack: assert property (@(posedge clk) disable iff (!arst_n)
      (|bus_wrce) |=> bus_wrack) else stop_failed("write strobe got no wrack");
   a_no_wrack: assert property (@(posedge clk) disable iff (!arst_n)
      !(|bus_wrce) |=> !bus_wrack) else stop_failed("wrack without a write strobe");
   a_rdack: assert property (@(posedge clk) disable iff (!arst_n)
      (|bus_rdce) |=> bus_rdack) else stop_failed("read strobe got no rdack");
   a_no_rdack: assert property (@(posedge clk) disable iff (!arst_n)
      !(|bus_rdce) |=> !bus_rdack) else stop_failed("rdack without a read strobe");
   a_error: assert property (@(posedge clk) bus_error == 1'b0)
      else stop_failed($sformatf("mismatch bus_error got %h exp 0", bus_error));
   a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
      bus_rdack |-> (bus_rdata & exp_mask) == exp_val)
      else stop_failed($sformatf("mismatch bus_rdata got %h exp %h mask %h",
                                 bus_rdata, exp_val, exp_mask));
   a_mosi: assert property (@(posedge clk) disable iff (!arst_n)
      rise_now |-> rise_cnt < 16 && serial_out == exp_frame[4'(15 - rise_cnt)])
      else stop_failed($sformatf("mismatch serial_out got %h exp %h at bit %0d",
                                 serial_out, exp_frame[4'(15 - rise_cnt)], rise_cnt));
   a_rises: assert property (@(posedge clk) rise_chk |-> rise_cnt == 16)
      else stop_failed($sformatf("mismatch spi_clk rises got %h exp %h", rise_cnt, 16));
   a_mem: assert property (@(posedge clk) mem_chk |-> chip.mem[chk_addr] == chk_data)
      else stop_failed($sformatf("mismatch chip.mem[%h] got %h exp %h",
                                 chk_addr, chip.mem[chk_addr], chk_data));
   a_soft_rst: assert property (@(posedge clk) sr_chk |-> !spi_clk)
      else stop_failed($sformatf("mismatch spi_clk got %h exp 0 after soft reset", spi_clk));

   initial begin
      logic [31:0] rd;
      logic [31:0] r;
      arst_n = 1'b0;
      bus_wrce = '0;
      bus_rdce = '0;
      bus_wdata = '0;
      lfsr = 32'h079bc0a7;
      exp_mask = '0;
      exp_val = '0;
      exp_frame = '0;
      spi_clk_q = 1'b0;
      rise_clr = 1'b0;
      rise_chk = 1'b0;
      mem_chk = 1'b0;
      sr_chk = 1'b0;
      chk_addr = '0;
      chk_data = '0;
      rise_cnt = 0;
      cycles = 0;
      for (int i = 0; i < 128; i++)
         ref_mem[i] = 8'(i) ^ 8'h5A;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      // reset values and readback with zero padding
      bus_read(spi_bridge_pkg::REG_WDATA, 32'hFFFF_FFFF, 32'h0, rd);
      bus_read(spi_bridge_pkg::REG_ADDR, 32'hFFFF_FFFF, 32'h0, rd);
      bus_read(spi_bridge_pkg::REG_CTRL, 32'hFFFF_FFFF, SRN, rd);
      take_bits(32, r);
      bus_write(spi_bridge_pkg::REG_WDATA, r);
      bus_read(spi_bridge_pkg::REG_WDATA, 32'hFFFF_FFFF, {24'h0, r[7:0]}, rd);
      take_bits(32, r);
      bus_write(spi_bridge_pkg::REG_ADDR, r);
      bus_read(spi_bridge_pkg::REG_ADDR, 32'hFFFF_FFFF, {24'h0, r[7:0]}, rd);

      for (int i = 0; i < 10; i++) begin
         take_bits(15, r);
         run_frame({1'b0, r[14:8]}, r[7:0]);
      end
      for (int i = 0; i < 10; i++) begin
         take_bits(15, r);
         run_frame({1'b1, r[14:8]}, r[7:0]);
      end

      // busy while running, second start ignored
      take_bits(15, r);
      start_frame({1'b0, r[14:8]}, r[7:0]);
      repeat (3) @(negedge clk);
      bus_read(spi_bridge_pkg::REG_STATUS, 32'h100, 32'h100, rd);
      bus_write(spi_bridge_pkg::REG_CTRL, GO | SRN);
      wait_done();
      pulse(rise_chk);
      ref_mem[r[14:8]] = r[7:0];
      bus_read(spi_bridge_pkg::REG_STATUS, 32'h300, 32'h0, rd); // second read, done cleared

      // soft reset in mid frame
      take_bits(15, r);
      start_frame({1'b0, r[14:8]}, r[7:0]);
      repeat (40) @(negedge clk);
      bus_write(spi_bridge_pkg::REG_CTRL, 32'h0);
      repeat (3) @(negedge clk);
      sr_chk = 1'b1; // spi_clk held low past where the frame would have ended
      repeat (spi_bridge_pkg::FRAME_BITS * 2 * CLK_DIV) @(negedge clk);
      sr_chk = 1'b0;
      bus_read(spi_bridge_pkg::REG_STATUS, 32'h200, 32'h0, rd);
      bus_write(spi_bridge_pkg::REG_CTRL, SRN);
      repeat (20) @(negedge clk);
      take_bits(15, r);
      run_frame({1'b0, r[14:8]}, r[7:0]);

      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/spi_chip_model.sv ====
// behavioral spi slave with 128 byte registers, answers mode 0 address/data frames from the bridge
`default_nettype none

module spi_chip_model #(
   parameter int IDLE_CYCLES = 12 // spi_clk low this long ends a partial frame
) (
   input  wire  clk,
   input  wire  spi_clk,
   input  wire  mosi,
   output logic miso
);

   logic [7:0]  mem [128];
   logic [15:0] sh;
   logic [7:0]  tx;
   logic        spi_clk_q;
   int          nbits;
   int          idle_cnt;

   initial begin
      for (int i = 0; i < 128; i++)
         mem[i] = 8'(i) ^ 8'h5A;
      miso      = 1'b0;
      sh        = '0;
      tx        = '0;
      spi_clk_q = 1'b0;
      nbits     = 0;
      idle_cnt  = 0;
   end

   always @(posedge clk) begin
      spi_clk_q <= spi_clk;
      if (spi_clk && !spi_clk_q) begin
         sh    <= {sh[14:0], mosi};
         nbits <= nbits + 1;
         if (nbits == 15) begin
            if (!sh[14]) // write frame
               mem[sh[13:7]] <= {sh[6:0], mosi};
            nbits <= 0;
         end
      end else if (!spi_clk && spi_clk_q) begin
         // address known after 8 bits, answer msb first
         if (nbits == 8 && sh[7]) begin
            miso <= mem[sh[6:0]][7];
            tx   <= {mem[sh[6:0]][6:0], 1'b0};
         end else if (nbits > 8) begin
            miso <= tx[7];
            tx   <= {tx[6:0], 1'b0};
         end
      end
      if (spi_clk) begin
         idle_cnt <= 0;
      end else if (idle_cnt >= IDLE_CYCLES) begin
         nbits <= 0;
         miso  <= 1'b0;
      end else begin
         idle_cnt <= idle_cnt + 1;
      end
   end

endmodule

`default_nettype wire

// ==== common/spi_bridge_pkg.sv ====
// register map, bus widths and engine states shared by every block of the spi bridge
`default_nettype none

package spi_bridge_pkg;

   typedef logic [31:0] bus_data_t;

   parameter int N_REG = 4;

   typedef logic [N_REG-1:0] reg_sel_t; // one-hot ce vector

   typedef logic [7:0] spi_byte_t;

   // register indices
   parameter int REG_STATUS = 0; // read only
   parameter int REG_WDATA  = 1;
   parameter int REG_ADDR   = 2;
   parameter int REG_CTRL   = 3;

   // status register bits, read byte sits in [7:0]
   parameter int STAT_BUSY_BIT = 8;
   parameter int STAT_DONE_BIT = 9;

   parameter int CTRL_GO_BIT        = 31; // self clearing
   parameter int CTRL_SOFT_RSTN_BIT = 30;

   parameter int ADDR_READ_BIT = 7; // set means read frame

   // address byte then data byte
   parameter int FRAME_BITS = 16;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SHIFT,
      ST_FINISH
   } spi_state_e;

endpackage

`default_nettype wire

// ==== common/spi_cmd_if.sv ====
// command path from the register decode into the spi engine
`default_nettype none

interface spi_cmd_if;

   logic                      start;     // one cycle pulse
   spi_bridge_pkg::spi_byte_t addr;
   spi_bridge_pkg::spi_byte_t wdata;
   logic                      soft_rstn; // level, low holds engine idle

   modport source (
      output start,
      output addr,
      output wdata,
      output soft_rstn
   );

   modport sink (
      input start,
      input addr,
      input wdata,
      input soft_rstn
   );

endinterface

`default_nettype wire

// ==== common/spi_result_if.sv ====
// frame results from the spi engine into result capture
`default_nettype none

interface spi_result_if;

   logic                      busy;
   logic                      done;    // pulse at frame end
   logic                      is_read; // valid with done
   spi_bridge_pkg::spi_byte_t rdata;

   modport source (
      output busy,
      output done,
      output is_read,
      output rdata
   );

   modport sink (
      input busy,
      input done,
      input is_read,
      input rdata
   );

endinterface

`default_nettype wire

// ==== hw/ipif_reg_decode.sv ====
// ipif register file with ce decode, acks and read mux, issues commands to the spi engine
`default_nettype none

module ipif_reg_decode (
   input  wire                             clk,
   input  wire                             arst_n,
   input  wire spi_bridge_pkg::reg_sel_t   bus_wrce,
   input  wire spi_bridge_pkg::reg_sel_t   bus_rdce,
   input  wire spi_bridge_pkg::bus_data_t  bus_wdata,
   output spi_bridge_pkg::bus_data_t       bus_rdata,
   output logic                            bus_wrack,
   output logic                            bus_rdack,
   spi_cmd_if.source                       cmd,
   input  wire spi_bridge_pkg::spi_byte_t  status_rdata,
   input  wire                             status_busy,
   input  wire                             status_done,
   output logic                            status_read
);

   spi_bridge_pkg::spi_byte_t wdata_q;
   spi_bridge_pkg::spi_byte_t addr_q;
   logic                      soft_rstn_q;
   logic                      start_q;
   spi_bridge_pkg::bus_data_t status_word;
   spi_bridge_pkg::bus_data_t ctrl_word;
   spi_bridge_pkg::bus_data_t rd_word;

   always_comb begin
      status_word = '0;
      status_word[7:0] = status_rdata;
      status_word[spi_bridge_pkg::STAT_BUSY_BIT] = status_busy;
      status_word[spi_bridge_pkg::STAT_DONE_BIT] = status_done;
   end

   // go bit never stored, reads back 0
   always_comb begin
      ctrl_word = '0;
      ctrl_word[spi_bridge_pkg::CTRL_SOFT_RSTN_BIT] = soft_rstn_q;
   end

   // zero when nothing selected
   always_comb begin
      rd_word = '0;
      if (bus_rdce[spi_bridge_pkg::REG_STATUS])
         rd_word = status_word;
      if (bus_rdce[spi_bridge_pkg::REG_WDATA])
         rd_word = spi_bridge_pkg::bus_data_t'(wdata_q);
      if (bus_rdce[spi_bridge_pkg::REG_ADDR])
         rd_word = spi_bridge_pkg::bus_data_t'(addr_q);
      if (bus_rdce[spi_bridge_pkg::REG_CTRL])
         rd_word = ctrl_word;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wdata_q     <= '0;
         addr_q      <= '0;
         soft_rstn_q <= 1'b1;
         start_q     <= 1'b0;
         bus_wrack   <= 1'b0;
         bus_rdack   <= 1'b0;
         bus_rdata   <= '0;
      end else begin
         bus_wrack <= |bus_wrce;
         bus_rdack <= |bus_rdce;
         bus_rdata <= rd_word;
         start_q   <= bus_wrce[spi_bridge_pkg::REG_CTRL] &
                      bus_wdata[spi_bridge_pkg::CTRL_GO_BIT];
         if (bus_wrce[spi_bridge_pkg::REG_WDATA])
            wdata_q <= spi_bridge_pkg::spi_byte_t'(bus_wdata);
         if (bus_wrce[spi_bridge_pkg::REG_ADDR])
            addr_q <= spi_bridge_pkg::spi_byte_t'(bus_wdata);
         if (bus_wrce[spi_bridge_pkg::REG_CTRL])
            soft_rstn_q <= bus_wdata[spi_bridge_pkg::CTRL_SOFT_RSTN_BIT];
      end
   end

   assign status_read = bus_rdce[spi_bridge_pkg::REG_STATUS]; // clears sticky done

   assign cmd.start     = start_q; // lines up with wrack
   assign cmd.addr      = addr_q;
   assign cmd.wdata     = wdata_q;
   assign cmd.soft_rstn = soft_rstn_q;

   a_ce_onehot: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0(bus_wrce) && $onehot0(bus_rdce));

   a_ce_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
      !((|bus_wrce) && (|bus_rdce)));

endmodule

`default_nettype wire

// ==== hw/spi_bridge_top.sv ====
// bus-to-spi register bridge top, plain ipif bus and spi pins around decode, engine and capture
`default_nettype none

module spi_bridge_top #(
   parameter int CLK_DIV = 4
) (
   input  wire                             clk,
   input  wire                             arst_n,
   input  wire spi_bridge_pkg::reg_sel_t   bus_wrce,
   input  wire spi_bridge_pkg::reg_sel_t   bus_rdce,
   input  wire spi_bridge_pkg::bus_data_t  bus_wdata,
   output spi_bridge_pkg::bus_data_t       bus_rdata,
   output logic                            bus_wrack,
   output logic                            bus_rdack,
   output logic                            bus_error,
   input  wire                             serial_in,
   output logic                            spi_clk,
   output logic                            serial_out
);

   spi_cmd_if    cmd_if ();
   spi_result_if res_if ();

   spi_bridge_pkg::spi_byte_t status_rdata;
   logic                      status_busy;
   logic                      status_done;
   logic                      status_read;

   assign bus_error = 1'b0; // no error responses

   ipif_reg_decode u_decode (
      .clk          (clk),
      .arst_n       (arst_n),
      .bus_wrce     (bus_wrce),
      .bus_rdce     (bus_rdce),
      .bus_wdata    (bus_wdata),
      .bus_rdata    (bus_rdata),
      .bus_wrack    (bus_wrack),
      .bus_rdack    (bus_rdack),
      .cmd          (cmd_if.source),
      .status_rdata (status_rdata),
      .status_busy  (status_busy),
      .status_done  (status_done),
      .status_read  (status_read)
   );

   spi_byte_master #(
      .CLK_DIV (CLK_DIV)
   ) u_master (
      .clk        (clk),
      .arst_n     (arst_n),
      .cmd        (cmd_if.sink),
      .res        (res_if.source),
      .serial_in  (serial_in),
      .spi_clk    (spi_clk),
      .serial_out (serial_out)
   );

   spi_result_capture u_capture (
      .clk          (clk),
      .arst_n       (arst_n),
      .res          (res_if.sink),
      .status_read  (status_read),
      .status_rdata (status_rdata),
      .status_busy  (status_busy),
      .status_done  (status_done)
   );

endmodule

`default_nettype wire

// ==== hw/spi_result_capture.sv ====
// keeps the last read byte, busy level and sticky done flag for the status register
`default_nettype none

module spi_result_capture (
   input  wire                 clk,
   input  wire                 arst_n,
   spi_result_if.sink          res,
   input  wire                 status_read,
   output spi_bridge_pkg::spi_byte_t status_rdata,
   output logic                status_busy,
   output logic                status_done
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         status_rdata <= '0;
         status_busy  <= 1'b0;
         status_done  <= 1'b0;
      end else begin
         status_busy <= res.busy; // one cycle behind the engine
         if (res.done && res.is_read)
            status_rdata <= res.rdata;
         // a new done beats the clearing read
         if (res.done)
            status_done <= 1'b1;
         else if (status_read)
            status_done <= 1'b0;
      end
   end

   a_done_in_frame: assert property (@(posedge clk) disable iff (!arst_n)
      res.done |-> $past(res.busy));

endmodule

`default_nettype wire

// ==== spi_engine/spi_byte_master.sv ====
// mode 0 spi master sending one 16-bit address/data frame per command, captures the read byte
`default_nettype none

module spi_byte_master #(
   parameter int CLK_DIV = 4 // clk cycles per spi_clk half period, at least 2
) (
   input  wire          clk,
   input  wire          arst_n,
   spi_cmd_if.sink      cmd,
   spi_result_if.source res,
   input  wire          serial_in,
   output logic         spi_clk,
   output logic         serial_out
);

   localparam int DIV_W = $clog2(CLK_DIV);
   localparam int CNT_W = $clog2(spi_bridge_pkg::FRAME_BITS + 1);
   localparam int BYTE_W = $bits(spi_bridge_pkg::spi_byte_t);

   typedef logic [DIV_W-1:0] div_cnt_t;
   typedef logic [CNT_W-1:0] bit_cnt_t;
   typedef logic [spi_bridge_pkg::FRAME_BITS-1:0] frame_t;

   spi_bridge_pkg::spi_state_e state;
   div_cnt_t                   div_cnt;
   bit_cnt_t                   bit_cnt; // completed bits
   frame_t                     shreg;
   logic                       is_read_q;
   spi_bridge_pkg::spi_byte_t  rdata_q;
   logic                       half_end;
   logic                       in_data_byte;

   assign half_end     = (div_cnt == div_cnt_t'(CLK_DIV - 1));
   assign in_data_byte = (bit_cnt >= bit_cnt_t'(BYTE_W));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= spi_bridge_pkg::ST_IDLE;
         div_cnt   <= '0;
         bit_cnt   <= '0;
         shreg     <= '0;
         spi_clk   <= 1'b0;
         is_read_q <= 1'b0;
      end else if (!cmd.soft_rstn) begin
         // soft reset, drop any frame without a done
         state   <= spi_bridge_pkg::ST_IDLE;
         div_cnt <= '0;
         bit_cnt <= '0;
         shreg   <= '0;
         spi_clk <= 1'b0;
      end else begin
         case (state)
            spi_bridge_pkg::ST_IDLE: begin
               if (cmd.start) begin
                  shreg     <= {cmd.addr, cmd.wdata}; // msb out first
                  is_read_q <= cmd.addr[spi_bridge_pkg::ADDR_READ_BIT];
                  div_cnt   <= '0;
                  bit_cnt   <= '0;
                  state     <= spi_bridge_pkg::ST_SHIFT;
               end
            end
            spi_bridge_pkg::ST_SHIFT: begin
               if (half_end) begin
                  div_cnt <= '0;
                  spi_clk <= ~spi_clk;
                  if (spi_clk) begin
                     // falling edge, next bit out
                     shreg   <= {shreg[spi_bridge_pkg::FRAME_BITS-2:0], 1'b0};
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == bit_cnt_t'(spi_bridge_pkg::FRAME_BITS - 1))
                        state <= spi_bridge_pkg::ST_FINISH;
                  end
               end else begin
                  div_cnt <= div_cnt + 1'b1;
               end
            end
            spi_bridge_pkg::ST_FINISH: begin
               state <= spi_bridge_pkg::ST_IDLE; // done cycle
            end
            default: begin
               state <= spi_bridge_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // sample on rising spi_clk, data byte of read frames only
   always_ff @(posedge clk) begin
      if (state == spi_bridge_pkg::ST_SHIFT && half_end && !spi_clk &&
          is_read_q && in_data_byte) begin
         rdata_q <= {rdata_q[BYTE_W-2:0], serial_in};
      end
   end

   assign serial_out = shreg[spi_bridge_pkg::FRAME_BITS-1];

   assign res.busy    = (state != spi_bridge_pkg::ST_IDLE);
   assign res.done    = (state == spi_bridge_pkg::ST_FINISH);
   assign res.is_read = is_read_q;
   assign res.rdata   = rdata_q;

   a_clk_low_idle: assert property (@(posedge clk) disable iff (!arst_n)
      state == spi_bridge_pkg::ST_IDLE |-> !spi_clk);

   a_bit_cnt_max: assert property (@(posedge clk) disable iff (!arst_n)
      bit_cnt <= bit_cnt_t'(spi_bridge_pkg::FRAME_BITS));

endmodule

`default_nettype wire
